/* Makefile */
SRCS := $(shell cat cart_ctrl.f)

.PHONY: run clean

obj_dir/Vcart_ctrl_tb: $(SRCS) cart_ctrl.f
	verilator --binary --timing --top-module cart_ctrl_tb -f cart_ctrl.f -o Vcart_ctrl_tb

run: obj_dir/Vcart_ctrl_tb
	./obj_dir/Vcart_ctrl_tb > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/cart_ctrl_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_ctrl_assertions (
  input wire logic clk2,
  input wire logic rst_n,
  input wire logic wb_cyc,
  input wire logic wb_stb,
  input wire logic wb_ack,
  input wire logic wb_we,
  input wire logic rom_we,
  input wire logic rom_data_oe
);

  // Ack only answers a live cycle
  ack_in_cycle: assert property (@(posedge clk2) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack outside a Wishbone cycle");

  ack_one_cycle: assert property (@(posedge clk2) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high for two cycles");

  // Write strobe needs the data drivers on and a live MCU write
  we_drives_data: assert property (@(posedge clk2) disable iff (!rst_n)
    !rom_we |-> (rom_data_oe && wb_cyc && wb_stb && wb_we))
    else $error("rom_we active without rom_data_oe or an MCU write cycle");

endmodule

`default_nettype wire

/* bench/cart_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_ctrl_tb;
  import cart_pkg::*;

  logic                   clk2 = 1'b0;
  logic                   rst_n;
  logic [snes_addr_w-1:0] snes_addr_in;
  logic                   snes_read_in;
  logic                   snes_cpu_clk_in = 1'b0;
  logic                   wb_cyc, wb_stb, wb_we, wb_ack;
  logic [snes_addr_w-1:0] wb_adr;
  logic [byte_w-1:0]      wb_dat_w, wb_dat_r, snes_data_out, rom_data_out;
  logic                   snes_data_oe, rd_start, snes_dead;
  logic [rom_data_w-1:0]  rom_data_in, wr_word;
  logic                   rom_data_oe, rom_bhe, rom_ble, rom_we;
  logic [rom_addr_w-1:0]  rom_addr;

  logic [rom_data_w-1:0]  rom_mem [logic [rom_addr_w-1:0]];  // ROM model, word wide
  logic [byte_w-1:0]      shadow [logic [snes_addr_w-1:0]];  // Bytes written by the MCU
  logic [snes_addr_w-1:0] addrs [8];
  logic [byte_w-1:0]      rdata;
  integer                 seed;
  int                     errors = 0, passed = 0, failed = 0, ack_cnt = 0, mem_gen = 0;
  int                     cpu_mode = 0;   // 0 low, 1 high, 2 toggling
  int                     cpu_half = 25, phase_cnt = 0;
  int                     rd_cnt = 0;     // rd_start pulses seen

  always #10 clk2 = ~clk2;

  cart_ctrl u_cart_ctrl (.*);

  bind cart_ctrl cart_ctrl_assertions u_cart_ctrl_assertions (
    .clk2(clk2), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .wb_we(wb_we), .rom_we(rom_we), .rom_data_oe(rom_data_oe)
  );

  // Erased contents, every address bit takes part
  function automatic logic [rom_data_w-1:0] fill_word(input logic [rom_addr_w-1:0] w);
    return w[15:0] ^ {w[22:16], w[22:14]};
  endfunction

  function automatic logic [rom_data_w-1:0] read_word(input logic [rom_addr_w-1:0] w);
    return rom_mem.exists(w) ? rom_mem[w] : fill_word(w);
  endfunction

  // Odd byte address lives in the low half of the word
  function automatic logic [byte_w-1:0] lane_of(input logic [snes_addr_w-1:0] b);
    logic [rom_data_w-1:0] w;
    w = read_word(b[23:1]);
    return b[0] ? w[7:0] : w[15:8];
  endfunction

  function automatic logic [byte_w-1:0] model_byte(input logic [snes_addr_w-1:0] b);
    logic [rom_data_w-1:0] w;
    w = fill_word(b[23:1]);
    if (shadow.exists(b)) return shadow[b];
    return b[0] ? w[7:0] : w[15:8];
  endfunction

  // LoROM, 32 KiB per bank with bank bit 7 ignored
  function automatic logic [snes_addr_w-1:0] lorom_map(input logic [snes_addr_w-1:0] a);
    return 24'(a[22:16]) * 24'h8000 + 24'(a[14:0]);
  endfunction

  //////////////////////////////////////////////////
  // ROM model and bus monitors
  //////////////////////////////////////////////////
  always @(rom_addr, mem_gen) rom_data_in = read_word(rom_addr);

  always @(posedge clk2) begin
    if (rst_n === 1'b1 && rom_we === 1'b0) begin
      wr_word = read_word(rom_addr);
      if (!rom_ble) wr_word[7:0] = rom_data_out;
      if (!rom_bhe) wr_word[15:8] = rom_data_out;
      rom_mem[rom_addr] = wr_word;
      mem_gen++;
    end
    if (wb_ack === 1'b1) ack_cnt++;
    if (rd_start === 1'b1) rd_cnt++;
  end

  // CPU clock source, driven on the falling edge
  always @(negedge clk2) begin
    if (cpu_mode == 0) snes_cpu_clk_in <= 1'b0;
    else if (cpu_mode == 1) snes_cpu_clk_in <= 1'b1;
    else if (phase_cnt >= cpu_half) begin
      snes_cpu_clk_in <= ~snes_cpu_clk_in;
      phase_cnt = 0;
    end else phase_cnt++;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk2);
  endtask

  task automatic wait_dead(input logic level);
    int n;
    n = 0;
    while (snes_dead !== level && n < snes_dead_timeout + 1000) begin
      @(negedge clk2);
      n++;
    end
    if (snes_dead !== level) begin
      $display("Timeout: snes_dead never became %0b", level);
      errors++;
    end
  endtask

  task automatic wb_start(input logic we, input logic [23:0] adr, input logic [7:0] dat);
    @(negedge clk2);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = dat;
  endtask

  task automatic wb_finish(input string name, output logic [7:0] rd);
    int n;
    n = 0;
    do begin
      @(negedge clk2);
      n++;
    end while (wb_ack !== 1'b1 && n < 3000);
    if (wb_ack !== 1'b1) begin
      $display("Timeout: no wb_ack for %s after %0d cycles", name, n);
      errors++;
    end
    rd = wb_dat_r;
    @(negedge clk2);  // Strobe drops in the cycle after the ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic mcu_write(input string name, input logic [23:0] adr, input logic [7:0] dat);
    logic [7:0] rd;
    wb_start(1'b1, adr, dat);
    wb_finish(name, rd);
    shadow[adr] = dat;
    check({name, " lane"}, 32'(dat), 32'(lane_of(adr)));
    check({name, " other lane"}, 32'(model_byte(adr ^ 24'd1)), 32'(lane_of(adr ^ 24'd1)));
  endtask

  task automatic mcu_read(input string name, input logic [23:0] adr);
    logic [7:0] rd;
    wb_start(1'b0, adr, 8'h00);
    wb_finish(name, rd);
    check(name, 32'(model_byte(adr)), 32'(rd));
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("PASS %s", name);
    end else begin
      failed++;
      $display("FAIL %s", name);
    end
  endtask

  initial begin
    int e0, n, acks0, rd0;
    logic [23:0] a;
    logic [7:0] d;
    seed = 32'hb703;
    rst_n = 1'b0;
    snes_addr_in = '0;
    snes_read_in = 1'b1;
    rom_data_in = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (3) @(negedge clk2);
    rst_n = 1'b1;
    idle(2);

    //////////////////////////////////////////////////
    // Dead console, then SNES reads
    //////////////////////////////////////////////////
    e0 = errors;
    check("dead after reset", 32'd1, 32'(snes_dead));
    check("rom_we after reset", 32'd1, 32'(rom_we));
    check("rom_data_oe after reset", 32'd0, 32'(rom_data_oe));
    check("wb_ack after reset", 32'd0, 32'(wb_ack));
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 24'($random(seed));
      mcu_write("dead write", addrs[i], 8'($random(seed)));
    end
    for (int i = 0; i < 8; i++) mcu_read("dead read", addrs[i]);
    end_test("dead_console_access", e0);

    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      a = (i < 8) ? (24'($random(seed)) | 24'h008000) : (24'($random(seed)) & 24'hbf7fff);
      rd0 = rd_cnt;
      @(negedge clk2);
      snes_addr_in = a;
      snes_read_in = 1'b0;
      idle(10);  // Sync pipeline latency
      check("snes oe", (i < 8) ? 32'd1 : 32'd0, 32'(snes_data_oe));
      if (i < 8) check("snes data", 32'(model_byte(lorom_map(a))), 32'(snes_data_out));
      check("rd_start pulses", 32'(rd0 + 1), 32'(rd_cnt));
      snes_read_in = 1'b1;
      idle(10);  // /RD history back to a stable high run
    end
    end_test("snes_rom_reads", e0);

    // Revival while an MCU write is in flight
    e0 = errors;
    acks0 = ack_cnt;
    a = 24'($random(seed));
    d = 8'($random(seed));
    wb_start(1'b1, a, d);
    n = 0;
    while (u_cart_ctrl.mcu_active !== 1'b1 && n < 100) begin
      @(negedge clk2);
      n++;
    end
    if (u_cart_ctrl.mcu_active !== 1'b1) begin
      $display("Timeout: MCU write never reached the ROM bus");
      errors++;
    end
    cpu_mode = 1;
    wait_dead(1'b0);
    cpu_mode = 2;
    wb_finish("revival write", rdata);
    shadow[a] = d;
    idle(4);
    check("revival acks", 32'(acks0 + 1), 32'(ack_cnt));
    check("revival lane", 32'(d), 32'(lane_of(a)));
    mcu_read("revival read", a);
    end_test("revival_restart", e0);

    // Back-pressure with a static CPU clock
    e0 = errors;
    cpu_mode = 1;
    idle(12);
    wait_dead(1'b0);
    wb_start(1'b0, addrs[0], 8'h00);
    for (int i = 0; i < 200; i++) begin
      @(negedge clk2);
      if (wb_ack === 1'b1) begin
        $display("wb_ack came while the ROM bus had no free slot");
        errors++;
      end
    end
    cpu_mode = 2;
    wb_finish("backpressure read", rdata);
    check("backpressure read", 32'(model_byte(addrs[0])), 32'(rdata));
    end_test("back_pressure", e0);

    //////////////////////////////////////////////////
    // Alive console, mixed traffic
    //////////////////////////////////////////////////
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      cpu_half = 21 + int'($random(seed) & 15);
      snes_addr_in = 24'($random(seed));
      a = ($random(seed) & 1) ? addrs[i % 8] : 24'($random(seed));
      if ($random(seed) & 1) mcu_write("alive write", a, 8'($random(seed)));
      else mcu_read("alive read", a);
    end
    end_test("alive_interleave", e0);

    $display("tests passed %0d failed %0d, %0d errors", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cart_ctrl.f */
logic/cart_pkg.sv
logic/snes_bus_sync.sv
logic/rom_arbiter.sv
logic/rom_bus_mux.sv
logic/cart_ctrl.sv
bench/cart_ctrl_assertions.sv
bench/cart_ctrl_tb.sv

/* logic/cart_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_ctrl
  import cart_pkg::*;
(
  input  wire logic                   clk2,
  input  wire logic                   rst_n,
  // SNES bus
  input  wire logic [snes_addr_w-1:0] snes_addr_in,
  input  wire logic                   snes_read_in,
  input  wire logic                   snes_cpu_clk_in,
  output logic      [byte_w-1:0]      snes_data_out,
  output logic                        snes_data_oe,
  output logic                        rd_start,
  output logic                        snes_dead,
  // MCU Wishbone port
  input  wire logic                   wb_cyc,
  input  wire logic                   wb_stb,
  input  wire logic                   wb_we,
  input  wire logic [snes_addr_w-1:0] wb_adr,
  input  wire logic [byte_w-1:0]      wb_dat_w,
  output logic                        wb_ack,
  output logic      [byte_w-1:0]      wb_dat_r,
  // ROM bus, 16 bit PSRAM
  input  wire logic [rom_data_w-1:0]  rom_data_in,
  output logic      [byte_w-1:0]      rom_data_out,
  output logic                        rom_data_oe,
  output logic      [rom_addr_w-1:0]  rom_addr,
  output logic                        rom_bhe,
  output logic                        rom_ble,
  output logic                        rom_we
);

  logic [snes_addr_w-1:0] snes_addr;
  logic                   snes_read;
  logic                   cpu_clk;
  logic                   cycle_start;
  logic                   cycle_end;
  logic                   rom_hit;
  logic [byte_w-1:0]      rom_byte;
  logic                   mcu_active;
  logic                   mcu_we_active;
  logic [snes_addr_w-1:0] mcu_addr;
  logic [byte_w-1:0]      mcu_wdata;

  snes_bus_sync u_snes_bus_sync (
    .clk2            (clk2),
    .rst_n           (rst_n),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_addr       (snes_addr),
    .snes_read       (snes_read),
    .cpu_clk         (cpu_clk),
    .cycle_start     (cycle_start),
    .cycle_end       (cycle_end),
    .rd_start        (rd_start),
    .snes_dead       (snes_dead)
  );

  rom_arbiter u_rom_arbiter (
    .clk2          (clk2),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_ack        (wb_ack),
    .wb_dat_r      (wb_dat_r),
    .cycle_start   (cycle_start),
    .cycle_end     (cycle_end),
    .cpu_clk       (cpu_clk),
    .snes_dead     (snes_dead),
    .rom_hit       (rom_hit),
    .rom_byte      (rom_byte),
    .mcu_active    (mcu_active),
    .mcu_we_active (mcu_we_active),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata)
  );

  rom_bus_mux u_rom_bus_mux (
    .snes_addr     (snes_addr),
    .snes_read     (snes_read),
    .mcu_active    (mcu_active),
    .mcu_we_active (mcu_we_active),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .rom_data_in   (rom_data_in),
    .rom_hit       (rom_hit),
    .rom_byte      (rom_byte),
    .rom_addr      (rom_addr),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .rom_we        (rom_we),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

`default_nettype wire

/* logic/cart_pkg.sv */
`default_nettype none

package cart_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////
  localparam int snes_addr_w = 24;
  localparam int rom_addr_w = 23;   // ROM word address
  localparam int byte_w = 8;
  localparam int rom_data_w = 16;

  //////////////////////////////////////////////////
  // Input synchronizer depths
  //////////////////////////////////////////////////
  localparam int sync_depth = 8;       // Control line history
  localparam int addr_sync_depth = 6;

  // ROM access timing, counter loads this and counts down to zero
  localparam int rom_cycle_len = 6;
  localparam int rom_dly_w = 3;

  // CPU clock low this long means no console, about 1 ms
  localparam int snes_dead_timeout = 80000;
  localparam int dead_cnt_w = 17;

  typedef enum logic [4:0] {
    st_idle        = 5'b00001,
    st_mcu_rd_addr = 5'b00010,
    st_mcu_rd_end  = 5'b00100,
    st_mcu_wr_addr = 5'b01000,
    st_mcu_wr_end  = 5'b10000
  } arb_state_t;

endpackage

`default_nettype wire

/* logic/rom_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter
  import cart_pkg::*;
(
  input  wire logic                   clk2,
  input  wire logic                   rst_n,
  // Wishbone classic slave
  input  wire logic                   wb_cyc,
  input  wire logic                   wb_stb,
  input  wire logic                   wb_we,
  input  wire logic [snes_addr_w-1:0] wb_adr,
  input  wire logic [byte_w-1:0]      wb_dat_w,
  output logic                        wb_ack,
  output logic      [byte_w-1:0]      wb_dat_r,
  // SNES bus status
  input  wire logic                   cycle_start,
  input  wire logic                   cycle_end,
  input  wire logic                   cpu_clk,
  input  wire logic                   snes_dead,
  input  wire logic                   rom_hit,
  input  wire logic [byte_w-1:0]      rom_byte,
  // To the ROM bus mux
  output logic                        mcu_active,
  output logic                        mcu_we_active,
  output logic      [snes_addr_w-1:0] mcu_addr,
  output logic      [byte_w-1:0]      mcu_wdata
);

  arb_state_t           state;
  logic [rom_dly_w-1:0] mem_dly;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 free_strobe;
  logic                 free_slot;
  logic                 access_end;

  assign access_end = (state == st_mcu_rd_end) || (state == st_mcu_wr_end);

  //////////////////////////////////////////////////
  // Request capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else if (wb_cyc && wb_stb && !rd_pend && !wr_pend) begin
      rd_pend <= !wb_we;
      wr_pend <= wb_we;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end
  end

  // Address and data held for the whole access
  always_ff @(posedge clk2) begin
    if (wb_cyc && wb_stb && !rd_pend && !wr_pend) begin
      mcu_addr  <= wb_adr;
      mcu_wdata <= wb_dat_w;
    end
  end

  //////////////////////////////////////////////////
  // Free bus slots
  //////////////////////////////////////////////////
  // A CPU cycle outside ROM leaves the ROM bus idle
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  //////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      state   <= st_idle;
      mem_dly <= '0;
    end else if (snes_dead && cpu_clk) begin
      state <= st_idle;  // Console woke up, abandon and retry later
    end else begin
      unique case (state)
        st_idle: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state   <= st_mcu_rd_addr;
              mem_dly <= rom_dly_w'(rom_cycle_len);
            end else if (wr_pend) begin
              state   <= st_mcu_wr_addr;
              mem_dly <= rom_dly_w'(rom_cycle_len);
            end
          end
        end
        st_mcu_rd_addr: begin
          mem_dly <= mem_dly - 1'b1;
          if (mem_dly == '0) state <= st_mcu_rd_end;
        end
        st_mcu_wr_addr: begin
          mem_dly <= mem_dly - 1'b1;
          if (mem_dly == '0) state <= st_mcu_wr_end;
        end
        st_mcu_rd_end, st_mcu_wr_end: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Last sample of the address phase is the one returned
  always_ff @(posedge clk2) begin
    if (state == st_mcu_rd_addr) wb_dat_r <= rom_byte;
  end

  assign wb_ack        = access_end;
  assign mcu_active    = (state == st_mcu_rd_addr) || (state == st_mcu_wr_addr);
  assign mcu_we_active = (state == st_mcu_wr_addr);

endmodule

`default_nettype wire

/* logic/rom_bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_bus_mux
  import cart_pkg::*;
(
  input  wire logic [snes_addr_w-1:0] snes_addr,
  input  wire logic                   snes_read,
  input  wire logic                   mcu_active,
  input  wire logic                   mcu_we_active,
  input  wire logic [snes_addr_w-1:0] mcu_addr,
  input  wire logic [byte_w-1:0]      mcu_wdata,
  input  wire logic [rom_data_w-1:0]  rom_data_in,
  output logic                        rom_hit,
  output logic      [byte_w-1:0]      rom_byte,
  output logic      [rom_addr_w-1:0]  rom_addr,
  output logic                        rom_bhe,
  output logic                        rom_ble,
  output logic                        rom_we,
  output logic      [byte_w-1:0]      rom_data_out,
  output logic                        rom_data_oe,
  output logic      [byte_w-1:0]      snes_data_out,
  output logic                        snes_data_oe
);

  logic [rom_addr_w:0] lorom_addr;   // Byte address
  logic [rom_addr_w:0] byte_addr;
  logic                lane_lo;

  //////////////////////////////////////////////////
  // LoROM mapping
  //////////////////////////////////////////////////
  // Upper half of banks $00-$3F/$80-$BF, plus all of $40-$7D/$C0-$FF
  assign rom_hit = snes_addr[15] | snes_addr[22];

  // Bank bits 6..0 over the 32 KiB window offset
  assign lorom_addr = {2'b00, snes_addr[22:16], snes_addr[14:0]};

  // MCU owns the bus during its address phase
  assign byte_addr = mcu_active ? mcu_addr[rom_addr_w:0] : lorom_addr;
  assign lane_lo   = byte_addr[0];

  assign rom_addr = byte_addr[rom_addr_w:1];
  assign rom_ble  = ~lane_lo;
  assign rom_bhe  = lane_lo;

  // Odd byte sits in the low half of the word
  assign rom_byte = lane_lo ? rom_data_in[byte_w-1:0] : rom_data_in[rom_data_w-1:byte_w];

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////
  assign rom_we       = ~mcu_we_active;  // Active low
  assign rom_data_oe  = mcu_we_active;
  assign rom_data_out = mcu_wdata;

  // SNES read data path
  assign snes_data_out = rom_byte;
  assign snes_data_oe  = ~snes_read & rom_hit;

endmodule

`default_nettype wire

/* logic/snes_bus_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync
  import cart_pkg::*;
(
  input  wire logic                   clk2,
  input  wire logic                   rst_n,
  input  wire logic [snes_addr_w-1:0] snes_addr_in,
  input  wire logic                   snes_read_in,
  input  wire logic                   snes_cpu_clk_in,
  output logic      [snes_addr_w-1:0] snes_addr,
  output logic                        snes_read,
  output logic                        cpu_clk,
  output logic                        cycle_start,
  output logic                        cycle_end,
  output logic                        rd_start,
  output logic                        snes_dead
);

  logic [sync_depth-1:0]  read_sr;
  logic [sync_depth-1:0]  cpu_clk_sr;
  logic [snes_addr_w-1:0] addr_pipe [addr_sync_depth];
  logic [dead_cnt_w-1:0]  dead_cnt;
  logic [sync_depth-3:0]  read_flt;    // Adjacent-pair AND of the read history
  logic [3:0]             clk_flt;

  //////////////////////////////////////////////////
  // Sample history, newest sample in bit 0
  //////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      read_sr    <= '1;    // /RD idle high
      cpu_clk_sr <= '0;
    end else begin
      read_sr    <= {read_sr[sync_depth-2:0], snes_read_in};
      cpu_clk_sr <= {cpu_clk_sr[sync_depth-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge clk2) begin
    addr_pipe[0] <= snes_addr_in;
    for (int i = 1; i < addr_sync_depth; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  // Two samples must agree before a level goes high
  assign snes_read = read_sr[2] & read_sr[1];
  assign cpu_clk   = cpu_clk_sr[2] & cpu_clk_sr[1];
  assign snes_addr = addr_pipe[addr_sync_depth-1] & addr_pipe[addr_sync_depth-2];

  //////////////////////////////////////////////////
  // Edge strobes, each one cycle wide
  //////////////////////////////////////////////////
  assign read_flt = read_sr[sync_depth-2:1] & read_sr[sync_depth-1:2];
  assign clk_flt  = cpu_clk_sr[4:1] & cpu_clk_sr[5:2];

  assign rd_start    = (read_flt == 6'b111110);  // /RD falling after a stable high run
  assign cycle_start = (clk_flt == 4'b0001);
  assign cycle_end   = (clk_flt == 4'b1110);

  //////////////////////////////////////////////////
  // Dead console detection
  //////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= dead_cnt_w'(snes_dead_timeout)) begin
      dead_cnt <= dead_cnt + 1'b1;  // Stops just past the timeout
    end
  end

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      snes_dead <= 1'b1;  // Assume no console until its clock runs
    end else if (cpu_clk) begin
      snes_dead <= 1'b0;
    end else if (dead_cnt > dead_cnt_w'(snes_dead_timeout)) begin
      snes_dead <= 1'b1;
    end
  end

endmodule

`default_nettype wire
